//--- ex_config.svh
/*
  widths, function codes and select codes for the execute cluster.
  MULT_BITS_PER_STEP must be a power of two that divides XLEN.
  FU_* indices fix the round-robin order right after reset.
*/
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// data path
`define XLEN                64
`define TAG_W               6
`define NUM_FU              3
`define MULT_BITS_PER_STEP  8

// bus requester indices
`define FU_ALU   0
`define FU_BR    1
`define FU_MULT  2

// alu function codes
`define ALU_ADDQ    5'h00
`define ALU_SUBQ    5'h01
`define ALU_AND     5'h02
`define ALU_BIC     5'h03
`define ALU_BIS     5'h04
`define ALU_ORNOT   5'h05
`define ALU_XOR     5'h06
`define ALU_EQV     5'h07
`define ALU_SRL     5'h08
`define ALU_SLL     5'h09
`define ALU_SRA     5'h0a
`define ALU_CMPULT  5'h0b
`define ALU_CMPEQ   5'h0c
`define ALU_CMPULE  5'h0d
`define ALU_CMPLT   5'h0e
`define ALU_CMPLE   5'h0f

// operand a select
`define OPA_IS_REGA      2'h0
`define OPA_IS_MEM_DISP  2'h1
`define OPA_IS_NPC       2'h2
`define OPA_IS_NOT3      2'h3

// operand b select, code 3 unused
`define OPB_IS_REGB     2'h0
`define OPB_IS_ALU_IMM  2'h1
`define OPB_IS_BR_DISP  2'h2

// marks an unused function or select code
`define BAD_RESULT  64'hdeadbeefbaadbeef

`endif

//--- ex_pkg.sv
/*
  shared types of the execute cluster.
  widths follow the macros in the config header.
*/
`include "ex_config.svh"

package ex_pkg;

  // data word and destination tag
  typedef logic [`XLEN-1:0]  word_t;
  typedef logic [`TAG_W-1:0] tag_t;

  // raw instruction, immediates come from here
  typedef logic [31:0] inst_t;

  // decoded control fields
  typedef logic [4:0] alu_func_t;
  typedef logic [1:0] opa_sel_t;
  typedef logic [1:0] opb_sel_t;

  // one bit per bus requester
  typedef logic [`NUM_FU-1:0] fu_vec_t;

  // iterative multiplier
  typedef enum logic [1:0] {MULT_IDLE, MULT_RUN, MULT_HOLD} mult_state_e;

endpackage

//--- alu.sv
/*
  combinational 64-bit integer ALU.
  shifts use the low 6 bits of opb only.
  compares return 0 or 1 in the low bit.
  unused function codes give BAD_RESULT.
*/
`include "ex_config.svh"

module alu (
  input  ex_pkg::word_t     opa,
  input  ex_pkg::word_t     opb,
  input  ex_pkg::alu_func_t func,
  output ex_pkg::word_t     result
);
  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;

  // signed a < b without a signed cast
  function automatic logic signed_lt(input word_t a, input word_t b);
    // same sign: plain unsigned compare is right
    if (a[`XLEN-1] == b[`XLEN-1]) begin
      return a < b;
    end
    // signs differ, the negative one is smaller
    return a[`XLEN-1];
  endfunction

  assign shamt = opb[SHAMT_W-1:0];

  always_comb begin
    case (func)
      // arithmetic
      `ALU_ADDQ:   result = opa + opb;
      `ALU_SUBQ:   result = opa - opb;
      // logic, with the inverted-b forms
      `ALU_AND:    result = opa & opb;
      `ALU_BIC:    result = opa & ~opb;
      `ALU_BIS:    result = opa | opb;
      `ALU_ORNOT:  result = opa | ~opb;
      `ALU_XOR:    result = opa ^ opb;
      `ALU_EQV:    result = opa ^ ~opb;
      // shifts
      `ALU_SRL:    result = opa >> shamt;
      `ALU_SLL:    result = opa << shamt;
      `ALU_SRA:    result = $signed(opa) >>> shamt;
      // compares, zero-extended flag
      `ALU_CMPULT: result = word_t'(opa < opb);
      `ALU_CMPEQ:  result = word_t'(opa == opb);
      `ALU_CMPULE: result = word_t'(opa <= opb);
      `ALU_CMPLT:  result = word_t'(signed_lt(opa, opb));
      `ALU_CMPLE:  result = word_t'(signed_lt(opa, opb) || (opa == opb));
      default:     result = `BAD_RESULT;
    endcase
  end

endmodule

//--- alu_unit.sv
/*
  ALU functional unit: operand muxes, immediates, one alu.
  result is captured on the issue edge and held until granted.
  busy equals req here, since the alu takes a single cycle.
  the issue stage must not issue while busy.
*/
`include "ex_config.svh"

module alu_unit (
  input  logic              clock,
  input  logic              rst_n,
  input  logic              issue,
  input  ex_pkg::inst_t     inst,
  input  ex_pkg::alu_func_t func,
  input  ex_pkg::opa_sel_t  opa_sel,
  input  ex_pkg::opb_sel_t  opb_sel,
  input  ex_pkg::word_t     rega,
  input  ex_pkg::word_t     regb,
  input  ex_pkg::word_t     npc,
  input  ex_pkg::tag_t      tag,
  input  logic              grant,
  output logic              busy,
  output logic              req,
  output ex_pkg::tag_t      req_tag,
  output ex_pkg::word_t     req_value
);
  import ex_pkg::*;

  word_t mem_disp;
  word_t br_disp;
  word_t alu_imm;
  word_t opa_mux;
  word_t opb_mux;
  word_t alu_result;

  //////////////////////////////////////////////////
  // immediates and operand select
  //////////////////////////////////////////////////

  // memory disp, sign-extended 16 bits
  assign mem_disp = {{(`XLEN-16){inst[15]}}, inst[15:0]};
  // branch disp, sign-extended 21 bits, word aligned
  assign br_disp  = {{(`XLEN-23){inst[20]}}, inst[20:0], 2'b00};
  // literal, zero-extended 8 bits
  assign alu_imm  = {{(`XLEN-8){1'b0}}, inst[20:13]};

  always_comb begin
    case (opa_sel)
      `OPA_IS_REGA:     opa_mux = rega;
      `OPA_IS_MEM_DISP: opa_mux = mem_disp;
      `OPA_IS_NPC:      opa_mux = npc;
      default:          opa_mux = ~word_t'(3);
    endcase
  end

  always_comb begin
    case (opb_sel)
      `OPB_IS_REGB:    opb_mux = regb;
      `OPB_IS_ALU_IMM: opb_mux = alu_imm;
      `OPB_IS_BR_DISP: opb_mux = br_disp;
      // bad select shows up on the bus
      default:         opb_mux = `BAD_RESULT;
    endcase
  end

  alu u_alu (
    .opa    (opa_mux),
    .opb    (opb_mux),
    .func   (func),
    .result (alu_result)
  );

  //////////////////////////////////////////////////
  // held result
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req <= 1'b0;
    end else if (issue) begin
      req <= 1'b1;
    end else if (grant) begin
      req <= 1'b0;
    end
  end

  // payload only, req qualifies it
  always_ff @(posedge clock) begin
    if (issue) begin
      req_tag   <= tag;
      req_value <= alu_result;
    end
  end

  assign busy = req;

  // issue stage honours busy
  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n) issue |-> !busy);
  // arbiter only grants a pending result
  a_grant_has_req: assert property (@(posedge clock) disable iff (!rst_n) grant |-> req);

endmodule

//--- branch_unit.sv
/*
  branch unit: condition test on rega, target, link value.
  take_branch and branch_target are valid one cycle after issue
  and never wait for the bus. branch_target holds only a meaning
  while take_branch is high. the link value (npc) goes out on the
  bus like any other result.
*/
`include "ex_config.svh"

module branch_unit (
  input  logic          clock,
  input  logic          rst_n,
  input  logic          issue,
  input  ex_pkg::inst_t inst,
  input  logic          uncond,
  input  logic          cond_br,
  input  ex_pkg::word_t rega,
  input  ex_pkg::word_t npc,
  input  ex_pkg::tag_t  tag,
  input  logic          grant,
  output logic          busy,
  output logic          take_branch,
  output ex_pkg::word_t branch_target,
  output logic          req,
  output ex_pkg::tag_t  req_tag,
  output ex_pkg::word_t req_value
);
  import ex_pkg::*;

  word_t br_disp;
  logic  cond_raw;
  logic  cond;

  assign br_disp = {{(`XLEN-23){inst[20]}}, inst[20:0], 2'b00};

  //////////////////////////////////////////////////
  // condition, bits 28:26
  //////////////////////////////////////////////////

  always_comb begin
    case (inst[27:26])
      // low bit clear
      2'b00: cond_raw = ~rega[0];
      // equal zero
      2'b01: cond_raw = (rega == '0);
      // negative, sign bit only
      2'b10: cond_raw = rega[`XLEN-1];
      // negative or zero
      default: cond_raw = rega[`XLEN-1] | (rega == '0);
    endcase
  end

  // bit 28 flips the sense
  assign cond = cond_raw ^ inst[28];

  // outcome, a one-cycle pulse
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      take_branch <= 1'b0;
    end else begin
      take_branch <= issue & (uncond | (cond_br & cond));
    end
  end

  //////////////////////////////////////////////////
  // link result towards the bus
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req <= 1'b0;
    end else if (issue) begin
      req <= 1'b1;
    end else if (grant) begin
      req <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      branch_target <= npc + br_disp;
      req_tag       <= tag;
      req_value     <= npc;
    end
  end

  assign busy = req;

  // a second branch would overwrite the pending link
  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n) issue |-> !busy);

endmodule

//--- mult_unit.sv
/*
  iterative shift-add multiplier, low XLEN bits of the product.
  retires MULT_BITS_PER_STEP multiplier bits per cycle, so it runs
  XLEN/MULT_BITS_PER_STEP cycles and then holds until granted.
  operand a is rega; operand b is regb or the 8-bit literal.
  busy from the issue edge until the grant edge.
*/
`include "ex_config.svh"

module mult_unit (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             issue,
  input  ex_pkg::inst_t    inst,
  input  ex_pkg::opb_sel_t opb_sel,
  input  ex_pkg::word_t    rega,
  input  ex_pkg::word_t    regb,
  input  ex_pkg::tag_t     tag,
  input  logic             grant,
  output logic             busy,
  output logic             req,
  output ex_pkg::tag_t     req_tag,
  output ex_pkg::word_t    req_value
);
  import ex_pkg::*;

  localparam int STEP      = `MULT_BITS_PER_STEP;
  localparam int NUM_STEPS = `XLEN / STEP;
  localparam int CNT_W     = $clog2(NUM_STEPS + 1);

  mult_state_e      state;
  logic [CNT_W-1:0] count;
  word_t            mcand;
  word_t            mplier;
  word_t            opb;
  word_t            partial;

  // literal or register operand b
  assign opb = (opb_sel == `OPB_IS_ALU_IMM) ? {{(`XLEN-8){1'b0}}, inst[20:13]} : regb;

  // low STEP multiplier bits times the shifted multiplicand
  assign partial = mcand * {{(`XLEN-STEP){1'b0}}, mplier[STEP-1:0]};

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= MULT_IDLE;
      count <= '0;
    end else begin
      case (state)
        MULT_IDLE: begin
          if (issue) begin
            state <= MULT_RUN;
            count <= '0;
          end
        end
        MULT_RUN: begin
          count <= count + 1'b1;
          // last step, result ready next cycle
          if (count == CNT_W'(NUM_STEPS - 1)) begin
            state <= MULT_HOLD;
          end
        end
        MULT_HOLD: begin
          if (grant) begin
            state <= MULT_IDLE;
          end
        end
        default: state <= MULT_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (state == MULT_IDLE && issue) begin
      mcand     <= rega;
      mplier    <= opb;
      req_value <= '0;
      req_tag   <= tag;
    end else if (state == MULT_RUN) begin
      // accumulate, then move on to the next bit group
      req_value <= req_value + partial;
      mcand     <= mcand << STEP;
      mplier    <= mplier >> STEP;
    end
  end

  assign busy = (state != MULT_IDLE);
  assign req  = (state == MULT_HOLD);

  a_no_issue_busy: assert property (@(posedge clock) disable iff (!rst_n) issue |-> !busy);
  // req only in HOLD, reached through a full run
  a_req_full_run: assert property (@(posedge clock) disable iff (!rst_n)
    $rose(req) |-> $past(state == MULT_RUN) && $past(state == MULT_RUN, NUM_STEPS));

endmodule

//--- cdb_arbiter.sv
/*
  round-robin owner of the common data bus.
  grant is combinational from req; the bus is registered, so
  cdb_valid pulses one cycle after each grant.
  priority starts just after the last winner; after reset the
  ALU unit comes first.
*/
`include "ex_config.svh"

module cdb_arbiter (
  input  logic            clock,
  input  logic            rst_n,
  input  ex_pkg::fu_vec_t req,
  input  ex_pkg::tag_t    req_tag0,
  input  ex_pkg::tag_t    req_tag1,
  input  ex_pkg::tag_t    req_tag2,
  input  ex_pkg::word_t   req_value0,
  input  ex_pkg::word_t   req_value1,
  input  ex_pkg::word_t   req_value2,
  output ex_pkg::fu_vec_t grant,
  output logic            cdb_valid,
  output ex_pkg::tag_t    cdb_tag,
  output ex_pkg::word_t   cdb_value
);
  import ex_pkg::*;

  localparam int IDX_W = $clog2(`NUM_FU);

  logic [IDX_W-1:0] last;
  logic [IDX_W-1:0] win_idx;
  logic             found;
  tag_t             win_tag;
  word_t            win_value;

  //////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////

  always_comb begin : pick
    int idx;
    grant   = '0;
    found   = 1'b0;
    win_idx = last;
    // walk from the unit after the last winner
    for (int i = 1; i <= `NUM_FU; i++) begin
      idx = (int'(last) + i) % `NUM_FU;
      if (!found && req[idx]) begin
        grant[idx] = 1'b1;
        win_idx    = IDX_W'(idx);
        found      = 1'b1;
      end
    end
  end

  // winner's payload
  always_comb begin
    case (win_idx)
      `FU_BR: begin
        win_tag   = req_tag1;
        win_value = req_value1;
      end
      `FU_MULT: begin
        win_tag   = req_tag2;
        win_value = req_value2;
      end
      default: begin
        win_tag   = req_tag0;
        win_value = req_value0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // bus register
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
      last      <= IDX_W'(`NUM_FU - 1);
    end else begin
      cdb_valid <= found;
      if (found) begin
        last <= win_idx;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (found) begin
      cdb_tag   <= win_tag;
      cdb_value <= win_value;
    end
  end

  // at most one winner, and only a unit that asked
  a_grant_legal: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~req) == '0));

endmodule

//--- ex_cluster.sv
/*
  execute cluster top: ALU, branch and multiplier units sharing
  one result bus through the round-robin arbiter.
  one instruction in flight per unit; issue only while busy is low.
*/
`include "ex_config.svh"

module ex_cluster (
  input  logic              clock,
  input  logic              rst_n,
  // alu unit issue
  input  logic              alu_issue,
  input  ex_pkg::inst_t     alu_inst,
  input  ex_pkg::alu_func_t alu_func,
  input  ex_pkg::opa_sel_t  alu_opa_sel,
  input  ex_pkg::opb_sel_t  alu_opb_sel,
  input  ex_pkg::word_t     alu_rega,
  input  ex_pkg::word_t     alu_regb,
  input  ex_pkg::word_t     alu_npc,
  input  ex_pkg::tag_t      alu_tag,
  output logic              alu_busy,
  // branch unit issue
  input  logic              br_issue,
  input  ex_pkg::inst_t     br_inst,
  input  logic              br_uncond,
  input  logic              br_cond_br,
  input  ex_pkg::word_t     br_rega,
  input  ex_pkg::word_t     br_npc,
  input  ex_pkg::tag_t      br_tag,
  output logic              br_busy,
  // multiplier issue
  input  logic              mul_issue,
  input  ex_pkg::inst_t     mul_inst,
  input  ex_pkg::opb_sel_t  mul_opb_sel,
  input  ex_pkg::word_t     mul_rega,
  input  ex_pkg::word_t     mul_regb,
  input  ex_pkg::tag_t      mul_tag,
  output logic              mul_busy,
  // branch outcome
  output logic              take_branch,
  output ex_pkg::word_t     branch_target,
  // result bus
  output logic              cdb_valid,
  output ex_pkg::tag_t      cdb_tag,
  output ex_pkg::word_t     cdb_value
);
  import ex_pkg::*;

  fu_vec_t req;
  fu_vec_t grant;
  tag_t    alu_req_tag;
  tag_t    br_req_tag;
  tag_t    mul_req_tag;
  word_t   alu_req_value;
  word_t   br_req_value;
  word_t   mul_req_value;

  alu_unit u_alu_unit (
    .clock     (clock),
    .rst_n     (rst_n),
    .issue     (alu_issue),
    .inst      (alu_inst),
    .func      (alu_func),
    .opa_sel   (alu_opa_sel),
    .opb_sel   (alu_opb_sel),
    .rega      (alu_rega),
    .regb      (alu_regb),
    .npc       (alu_npc),
    .tag       (alu_tag),
    .grant     (grant[`FU_ALU]),
    .busy      (alu_busy),
    .req       (req[`FU_ALU]),
    .req_tag   (alu_req_tag),
    .req_value (alu_req_value)
  );

  branch_unit u_branch_unit (
    .clock         (clock),
    .rst_n         (rst_n),
    .issue         (br_issue),
    .inst          (br_inst),
    .uncond        (br_uncond),
    .cond_br       (br_cond_br),
    .rega          (br_rega),
    .npc           (br_npc),
    .tag           (br_tag),
    .grant         (grant[`FU_BR]),
    .busy          (br_busy),
    .take_branch   (take_branch),
    .branch_target (branch_target),
    .req           (req[`FU_BR]),
    .req_tag       (br_req_tag),
    .req_value     (br_req_value)
  );

  mult_unit u_mult_unit (
    .clock     (clock),
    .rst_n     (rst_n),
    .issue     (mul_issue),
    .inst      (mul_inst),
    .opb_sel   (mul_opb_sel),
    .rega      (mul_rega),
    .regb      (mul_regb),
    .tag       (mul_tag),
    .grant     (grant[`FU_MULT]),
    .busy      (mul_busy),
    .req       (req[`FU_MULT]),
    .req_tag   (mul_req_tag),
    .req_value (mul_req_value)
  );

  // requester n of the arbiter is unit index n
  cdb_arbiter u_cdb_arbiter (
    .clock      (clock),
    .rst_n      (rst_n),
    .req        (req),
    .req_tag0   (alu_req_tag),
    .req_tag1   (br_req_tag),
    .req_tag2   (mul_req_tag),
    .req_value0 (alu_req_value),
    .req_value1 (br_req_value),
    .req_value2 (mul_req_value),
    .grant      (grant),
    .cdb_valid  (cdb_valid),
    .cdb_tag    (cdb_tag),
    .cdb_value  (cdb_value)
  );

endmodule

//--- tb_ex_cluster.sv
/*
  testbench for the execute cluster, random issue from a fixed seed.
  expected values come from a model in this file, kept per tag.
  tags wrap at 2**TAG_W which is safe while at most three are in flight.
  latency limits assume MULT_BITS_PER_STEP divides XLEN.
*/
`include "ex_config.svh"

module tb_ex_cluster;
  import ex_pkg::*;

  localparam int CLK_HALF      = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int NUM_CYCLES    = 400;
  localparam int NUM_TAGS      = 1 << `TAG_W;
  localparam int MULT_CYCLES   = `XLEN / `MULT_BITS_PER_STEP;
  localparam int WATCHDOG_TIME = (NUM_CYCLES + 64) * (2 * CLK_HALF) * 2;

  logic      clock = 1'b0;
  logic      rst_n;
  logic      alu_issue;
  inst_t     alu_inst;
  alu_func_t alu_func;
  opa_sel_t  alu_opa_sel;
  opb_sel_t  alu_opb_sel;
  word_t     alu_rega;
  word_t     alu_regb;
  word_t     alu_npc;
  tag_t      alu_tag;
  logic      alu_busy;
  logic      br_issue;
  inst_t     br_inst;
  logic      br_uncond;
  logic      br_cond_br;
  word_t     br_rega;
  word_t     br_npc;
  tag_t      br_tag;
  logic      br_busy;
  logic      mul_issue;
  inst_t     mul_inst;
  opb_sel_t  mul_opb_sel;
  word_t     mul_rega;
  word_t     mul_regb;
  tag_t      mul_tag;
  logic      mul_busy;
  logic      take_branch;
  word_t     branch_target;
  logic      cdb_valid;
  tag_t      cdb_tag;
  word_t     cdb_value;

  integer seed;
  int     errors;
  int     checks;
  int     cycle;
  int     in_flight;
  int     rst_release_edge;
  tag_t   next_tag;

  // scoreboard with one slot per tag
  logic  outstanding [NUM_TAGS];
  word_t expect_value [NUM_TAGS];
  int    pend_edge [NUM_TAGS];
  int    others_seen [NUM_TAGS];

  // branch outcome due after this edge
  int    br_issue_edge;
  logic  exp_take;
  word_t exp_target;

  ex_cluster u_ex_cluster (.*);

  always #CLK_HALF clock = ~clock;

  // edges seen so far
  always @(posedge clock) cycle = cycle + 1;

  //////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, actual, expected);
    end
  endtask

  task automatic report_error(input string what);
    errors = errors + 1;
    $display("error at time %0t: %s", $time, what);
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  // mix of edge values and plain random words
  function automatic word_t pick_operand();
    logic [31:0] r;
    r = rand32();
    case (r[2:0])
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return {1'b1, {(`XLEN-1){1'b0}}};
      default: return {rand32(), rand32()};
    endcase
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic word_t alu_model(input alu_func_t f, input word_t a, input word_t b);
    logic [5:0] sh;
    word_t      ones;
    sh   = b[5:0];
    ones = '1;
    case (f)
      `ALU_ADDQ:   return a + b;
      `ALU_SUBQ:   return a - b;
      `ALU_AND:    return a & b;
      `ALU_BIC:    return a & ~b;
      `ALU_BIS:    return a | b;
      `ALU_ORNOT:  return a | ~b;
      `ALU_XOR:    return a ^ b;
      `ALU_EQV:    return ~(a ^ b);
      `ALU_SRL:    return a >> sh;
      `ALU_SLL:    return a << sh;
      // logical shift and then a sign fill of the top bits
      `ALU_SRA:    return (a >> sh) | (a[`XLEN-1] ? ~(ones >> sh) : '0);
      `ALU_CMPULT: return word_t'(a < b);
      `ALU_CMPEQ:  return word_t'(a == b);
      `ALU_CMPULE: return word_t'(a <= b);
      `ALU_CMPLT:  return word_t'($signed(a) < $signed(b));
      `ALU_CMPLE:  return word_t'($signed(a) <= $signed(b));
      default:     return `BAD_RESULT;
    endcase
  endfunction

  function automatic logic branch_holds(input inst_t i, input word_t a);
    logic c;
    case (i[27:26])
      2'd0: c = (a[0] == 1'b0);
      2'd1: c = (a == '0);
      2'd2: c = a[`XLEN-1];
      default: c = a[`XLEN-1] || (a == '0);
    endcase
    return c ^ i[28];
  endfunction

  function automatic word_t br_disp_of(input inst_t i);
    word_t d;
    d = {{(`XLEN-21){i[20]}}, i[20:0]};
    return d << 2;
  endfunction

  // pend_offset counts edges from issue until the unit requests the bus
  task automatic record_issue(input tag_t t, input word_t value, input int pend_offset);
    if (outstanding[t]) begin
      report_error($sformatf("tag %0d issued again while still outstanding", t));
    end
    outstanding[t]  = 1'b1;
    expect_value[t] = value;
    pend_edge[t]    = cycle + 1 + pend_offset;
    others_seen[t]  = 0;
    in_flight       = in_flight + 1;
    next_tag        = next_tag + 1'b1;
  endtask

  //////////////////////////////////////////////////
  // issue tasks
  //////////////////////////////////////////////////

  task automatic issue_alu();
    logic [31:0] r;
    word_t       a;
    word_t       b;
    r           = rand32();
    // mostly legal codes and a few unused ones
    alu_func    = r[5] ? r[4:0] : {1'b0, r[3:0]};
    alu_opa_sel = r[7:6];
    alu_opb_sel = (r[9:8] == 2'd3) ? `OPB_IS_REGB : r[9:8];
    alu_inst    = rand32();
    alu_rega    = pick_operand();
    alu_regb    = pick_operand();
    alu_npc     = {rand32(), rand32()};
    alu_tag     = next_tag;
    case (alu_opa_sel)
      `OPA_IS_REGA:     a = alu_rega;
      `OPA_IS_MEM_DISP: a = {{(`XLEN-16){alu_inst[15]}}, alu_inst[15:0]};
      `OPA_IS_NPC:      a = alu_npc;
      default:          a = ~word_t'(3);
    endcase
    case (alu_opb_sel)
      `OPB_IS_ALU_IMM: b = {{(`XLEN-8){1'b0}}, alu_inst[20:13]};
      `OPB_IS_BR_DISP: b = br_disp_of(alu_inst);
      default:         b = alu_regb;
    endcase
    alu_issue = 1'b1;
    record_issue(next_tag, alu_model(alu_func, a, b), 0);
  endtask

  task automatic issue_branch();
    logic [31:0] r;
    r          = rand32();
    br_uncond  = (r[1:0] == 2'd0);
    br_cond_br = !br_uncond && r[2];
    br_inst    = rand32();
    br_rega    = pick_operand();
    br_npc     = {rand32(), rand32()};
    br_tag     = next_tag;
    br_issue   = 1'b1;
    br_issue_edge = cycle + 1;
    exp_take      = br_uncond || (br_cond_br && branch_holds(br_inst, br_rega));
    exp_target    = br_npc + br_disp_of(br_inst);
    // link value is the next pc
    record_issue(next_tag, br_npc, 0);
  endtask

  task automatic issue_mult();
    logic [31:0] r;
    word_t       b;
    r           = rand32();
    mul_opb_sel = (r[1:0] == 2'd3) ? `OPB_IS_REGB : r[1:0];
    mul_inst    = rand32();
    mul_rega    = pick_operand();
    mul_regb    = pick_operand();
    mul_tag     = next_tag;
    b = (mul_opb_sel == `OPB_IS_ALU_IMM) ? {{(`XLEN-8){1'b0}}, mul_inst[20:13]} : mul_regb;
    mul_issue = 1'b1;
    // low XLEN bits of the product
    record_issue(next_tag, mul_rega * b, MULT_CYCLES);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] coin;
    seed      = 32'ha1ee_d549;
    errors    = 0;
    checks    = 0;
    cycle     = 0;
    in_flight = 0;
    next_tag  = '0;
    br_issue_edge    = -1;
    rst_release_edge = -1;
    exp_take   = 1'b0;
    exp_target = '0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      outstanding[t] = 1'b0;
    end
    rst_n       = 1'b0;
    alu_issue   = 1'b0;
    alu_inst    = '0;
    alu_func    = '0;
    alu_opa_sel = '0;
    alu_opb_sel = '0;
    alu_rega    = '0;
    alu_regb    = '0;
    alu_npc     = '0;
    alu_tag     = '0;
    br_issue    = 1'b0;
    br_inst     = '0;
    br_uncond   = 1'b0;
    br_cond_br  = 1'b0;
    br_rega     = '0;
    br_npc      = '0;
    br_tag      = '0;
    mul_issue   = 1'b0;
    mul_inst    = '0;
    mul_opb_sel = '0;
    mul_rega    = '0;
    mul_regb    = '0;
    mul_tag     = '0;

    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    rst_n = 1'b1;
    rst_release_edge = cycle;

    // each idle unit gets an instruction half the time
    repeat (NUM_CYCLES) begin
      @(posedge clock);
      #1;
      alu_issue = 1'b0;
      br_issue  = 1'b0;
      mul_issue = 1'b0;
      coin = rand32();
      if (!alu_busy && coin[0]) begin
        issue_alu();
      end
      if (!br_busy && coin[1]) begin
        issue_branch();
      end
      if (!mul_busy && coin[2]) begin
        issue_mult();
      end
    end
    @(posedge clock);
    #1;
    alu_issue = 1'b0;
    br_issue  = 1'b0;
    mul_issue = 1'b0;

    // drain and then wait a few quiet cycles for stray broadcasts
    while (in_flight != 0) begin
      @(posedge clock);
    end
    repeat (4) @(posedge clock);
    #1;
    check_value("alu_busy", word_t'(alu_busy), '0);
    check_value("br_busy", word_t'(br_busy), '0);
    check_value("mul_busy", word_t'(mul_busy), '0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  //////////////////////////////////////////////////
  // monitors sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clock) begin : bus_monitor
    tag_t t;
    if (!rst_n || cycle == rst_release_edge + 1) begin
      // reset state
      check_value("cdb_valid", word_t'(cdb_valid), '0);
      check_value("take_branch", word_t'(take_branch), '0);
      check_value("alu_busy", word_t'(alu_busy), '0);
      check_value("br_busy", word_t'(br_busy), '0);
      check_value("mul_busy", word_t'(mul_busy), '0);
    end else begin
      // branch outcome one cycle after issue
      if (cycle == br_issue_edge) begin
        check_value("take_branch", word_t'(take_branch), word_t'(exp_take));
        check_value("branch_target", branch_target, exp_target);
      end else begin
        check_value("take_branch", word_t'(take_branch), '0);
      end

      if (cdb_valid) begin
        t = cdb_tag;
        if (!outstanding[t]) begin
          report_error($sformatf("bus carried tag %0d, which was not outstanding", t));
        end else begin
          check_value("cdb_value", cdb_value, expect_value[t]);
          if (cycle < pend_edge[t] + 1) begin
            report_error($sformatf("tag %0d reached the bus too early", t));
          end
          if (others_seen[t] > `NUM_FU - 1) begin
            report_error($sformatf("tag %0d waited behind %0d other results",
                                   t, others_seen[t]));
          end
          outstanding[t] = 1'b0;
          in_flight      = in_flight - 1;
        end
        // this broadcast competed with every other pending result
        for (int u = 0; u < NUM_TAGS; u++) begin
          if (outstanding[u] && cycle >= pend_edge[u] + 1) begin
            others_seen[u] = others_seen[u] + 1;
          end
        end
      end
    end
  end

  initial begin : watchdog
    #WATCHDOG_TIME;
    $display("watchdog expired with %0d results still outstanding", in_flight);
    $display("test failed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
ex_pkg.sv
alu.sv
alu_unit.sv
branch_unit.sv
mult_unit.sv
cdb_arbiter.sv
ex_cluster.sv
tb_ex_cluster.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_ex_cluster \
  -f tb.f \
  -o sim_ex_cluster

output="$(./obj_dir/sim_ex_cluster 2>&1)"
echo "$output"

if grep -qx "test passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
